// ==== build.f ====
verilog/sram_pkg.sv
verilog/sram_bitline_if.sv
verilog/sram_ctrl.sv
verilog/sense_timer.sv
verilog/sipo.sv
verilog/cell_array.sv
verilog/sense_amp.sv
verilog/sram_top.sv
test/sram_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SRAM testbench with Verilator, all output goes to sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module sram_tb -f build.f -o sram_sim > sim.log 2>&1 &&
	./obj_dir/sram_sim >> sim.log 2>&1 ||
	echo "TB FAILED" >> sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== test/sram_tb.sv ====
`timescale 1ns/1ps

module sram_tb;
	import sram_pkg::*;

	// Edges from the r_en edge (counted as 1) until data_valid is seen
	localparam int READ_LATENCY = SENSE_CYCLES + 2;
	localparam int READ_TIMEOUT = 20;
	// Quiet window after a combined write and read pulse
	localparam int BOTH_WINDOW  = 10;

	typedef enum {
		OP_WRITE,
		OP_READ,
		OP_SHIFT_READ,
		OP_WRITE_HELD,
		OP_BUSY_READ,
		OP_BOTH
	} op_t;

	typedef struct {
		op_t       op;
		row_addr_t addr;
		word_t     data;
		word_t     expected;
	} entry_t;

	logic      clk;
	logic      rst_n;
	logic      serial_in;
	logic      shift;
	logic      w_en;
	logic      r_en;
	row_addr_t addr;
	logic      data_valid;
	word_t     data_out;

	entry_t      table_q [$];
	logic        shift_bits [$];
	word_t       shadow_mem [ROWS];
	word_t       shadow_sipo;
	logic [31:0] lcg_state;

	sram_top sram_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.serial_in  (serial_in),
		.shift      (shift),
		.w_en       (w_en),
		.r_en       (r_en),
		.addr       (addr),
		.data_valid (data_valid),
		.data_out   (data_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_word(word_t got, word_t exp, string name);
		if (got !== exp) begin
			report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_flag(logic got, logic exp, string name);
		if (got !== exp) begin
			report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_latency(int got, int exp);
		string msg;
		if (got != exp) begin
			msg = $sformatf("wrong read latency: data_valid after %0d cycles, expected %0d",
				got, exp);
			report_failure(msg);
		end
	endtask

	// Advance to the next falling edge, feeding one queued serial bit if any
	task automatic next_cycle();
		@(negedge clk);
		if (shift_bits.size() > 0) begin
			serial_in = shift_bits.pop_front();
			shift     = 1'b1;
		end else begin
			serial_in = 1'b0;
			shift     = 1'b0;
		end
	endtask

	// MSB goes out first
	task automatic push_word(word_t w);
		for (int i = COLS - 1; i >= 0; i--) begin
			shift_bits.push_back(w[i]);
		end
	endtask

	task automatic drain_shift();
		int guard;
		guard = 0;
		while (shift_bits.size() > 0) begin
			if (guard > 2 * COLS) begin
				report_failure("serial shift queue did not empty");
			end
			next_cycle();
			guard++;
		end
	endtask

	task automatic pulse_write(row_addr_t a);
		drain_shift();
		next_cycle();
		w_en = 1'b1;
		addr = a;
		next_cycle();
		w_en = 1'b0;
	endtask

	// Optional w_en pulse lands in the PRECHARGE cycle of the read
	task automatic do_read(row_addr_t a, word_t exp, bit busy_write);
		int cycles;
		next_cycle();
		r_en = 1'b1;
		addr = a;
		next_cycle();
		r_en   = 1'b0;
		w_en   = busy_write;
		cycles = 1;
		while (data_valid !== 1'b1) begin
			if (cycles >= READ_TIMEOUT) begin
				report_failure($sformatf("timeout: data_valid never came for row %0d", a));
			end
			next_cycle();
			w_en = 1'b0;
			cycles++;
		end
		check_latency(cycles, READ_LATENCY);
		check_word(data_out, exp, "data_out");
		next_cycle();
		check_flag(data_valid, 1'b0, "data_valid");
		check_word(data_out, exp, "data_out");
	endtask

	task automatic write_and_read(row_addr_t a);
		drain_shift();
		next_cycle();
		w_en = 1'b1;
		r_en = 1'b1;
		addr = a;
		next_cycle();
		w_en = 1'b0;
		r_en = 1'b0;
		for (int i = 0; i < BOTH_WINDOW; i++) begin
			next_cycle();
			check_flag(data_valid, 1'b0, "data_valid");
		end
	endtask

	// Shadow model of the cells and the shift register gives the expected value
	task automatic add_entry(op_t op, row_addr_t a, word_t d);
		entry_t e;
		e.op   = op;
		e.addr = a;
		e.data = d;
		case (op)
			OP_WRITE, OP_BOTH: begin
				shadow_sipo   = d;
				shadow_mem[a] = d;
				e.expected    = d;
			end
			OP_WRITE_HELD: begin
				shadow_mem[a] = shadow_sipo;
				e.expected    = shadow_sipo;
			end
			OP_SHIFT_READ, OP_BUSY_READ: begin
				e.expected  = shadow_mem[a];
				shadow_sipo = d;
			end
			default: begin
				e.expected = shadow_mem[a];
			end
		endcase
		table_q.push_back(e);
	endtask

	task automatic build_table();
		int order [ROWS];
		int j;
		int tmp;
		for (int r = 0; r < ROWS; r++) begin
			shadow_mem[r] = '0;
		end
		shadow_sipo = '0;
		// Unwritten rows read as zero
		add_entry(OP_READ, row_addr_t'(0), '0);
		add_entry(OP_READ, row_addr_t'(9), '0);
		add_entry(OP_READ, row_addr_t'(15), '0);
		// Asymmetric pattern shows the serial bit order
		add_entry(OP_WRITE, row_addr_t'(3), 8'hC5);
		add_entry(OP_READ, row_addr_t'(3), '0);
		// Fill every row, then read back in shuffled order
		for (int r = 0; r < ROWS; r++) begin
			add_entry(OP_WRITE, row_addr_t'(r), word_t'(lcg_next() >> 16));
			order[r] = r;
		end
		for (int i = ROWS - 1; i > 0; i--) begin
			j        = int'((lcg_next() >> 16) % 32'(i + 1));
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < ROWS; i++) begin
			add_entry(OP_READ, row_addr_t'(order[i]), '0);
		end
		// Overwrite and neighbours
		add_entry(OP_WRITE, row_addr_t'(5), word_t'(lcg_next() >> 16));
		add_entry(OP_WRITE, row_addr_t'(5), word_t'(lcg_next() >> 16));
		add_entry(OP_READ, row_addr_t'(5), '0);
		add_entry(OP_READ, row_addr_t'(4), '0);
		add_entry(OP_READ, row_addr_t'(6), '0);
		// Busy and priority
		add_entry(OP_BUSY_READ, row_addr_t'(7), word_t'(lcg_next() >> 16));
		add_entry(OP_READ, row_addr_t'(7), '0);
		add_entry(OP_BOTH, row_addr_t'(8), word_t'(lcg_next() >> 16));
		add_entry(OP_READ, row_addr_t'(8), '0);
		// Shifting while a read is in flight
		add_entry(OP_SHIFT_READ, row_addr_t'(9), word_t'(lcg_next() >> 16));
		add_entry(OP_WRITE_HELD, row_addr_t'(10), '0);
		add_entry(OP_READ, row_addr_t'(10), '0);
		add_entry(OP_READ, row_addr_t'(9), '0);
	endtask

	task automatic apply_entry(entry_t e);
		case (e.op)
			OP_WRITE: begin
				push_word(e.data);
				pulse_write(e.addr);
			end
			OP_READ: begin
				do_read(e.addr, e.expected, 1'b0);
			end
			OP_SHIFT_READ: begin
				push_word(e.data);
				do_read(e.addr, e.expected, 1'b0);
			end
			OP_WRITE_HELD: begin
				pulse_write(e.addr);
			end
			OP_BUSY_READ: begin
				push_word(e.data);
				drain_shift();
				do_read(e.addr, e.expected, 1'b1);
			end
			OP_BOTH: begin
				push_word(e.data);
				write_and_read(e.addr);
			end
			default: begin
				report_failure("unknown operation in the stimulus table");
			end
		endcase
	endtask

	initial begin
		rst_n     = 1'b0;
		serial_in = 1'b0;
		shift     = 1'b0;
		w_en      = 1'b0;
		r_en      = 1'b0;
		addr      = '0;
		lcg_state = 32'd43424;
		build_table();
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		check_flag(data_valid, 1'b0, "data_valid");
		check_word(data_out, '0, "data_out");
		for (int i = 0; i < table_q.size(); i++) begin
			apply_entry(table_q[i]);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== verilog/sram_top.sv ====
`timescale 1ns/1ps

module sram_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                serial_in,
	input  logic                shift,
	input  logic                w_en,
	input  logic                r_en,
	input  sram_pkg::row_addr_t addr,
	output logic                data_valid,
	output sram_pkg::word_t     data_out
);
	import sram_pkg::*;

	// Serial write path
	word_t parallel_out;

	// Controller to timer and write driver
	logic sense_start;
	logic sense_done;
	logic accept_write;

	// Wordlines, bitline pair and phase strobes
	sram_bitline_if bus1 ();

	sipo sipo1 (
		.clk          (clk),
		.rst_n        (rst_n),
		.serial_in    (serial_in),
		.shift        (shift),
		.parallel_out (parallel_out)
	);

	sram_ctrl ctrl1 (
		.clk          (clk),
		.rst_n        (rst_n),
		.w_en         (w_en),
		.r_en         (r_en),
		.addr         (addr),
		.sense_done   (sense_done),
		.sense_start  (sense_start),
		.accept_write (accept_write),
		.bus          (bus1.ctrl)
	);

	// Holds the sense phase open for SENSE_CYCLES clocks
	sense_timer timer1 (
		.clk   (clk),
		.rst_n (rst_n),
		.start (sense_start),
		.done  (sense_done)
	);

	cell_array cell1 (
		.clk          (clk),
		.rst_n        (rst_n),
		.write_data   (parallel_out),
		.accept_write (accept_write),
		.bus          (bus1.array)
	);

	sense_amp amp1 (
		.clk        (clk),
		.rst_n      (rst_n),
		.bus        (bus1.sense),
		.data_valid (data_valid),
		.data_out   (data_out)
	);

endmodule

// ==== verilog/sense_amp.sv ====
`timescale 1ns/1ps

module sense_amp (
	input  logic            clk,
	input  logic            rst_n,
	sram_bitline_if.sense   bus,
	output logic            data_valid,
	output sram_pkg::word_t data_out
);
	import sram_pkg::*;

	word_t resolved;

	// A column resolves to bl only where the pair has split,
	// an unsplit column reads as zero
	always_comb begin
		for (int c = 0; c < COLS; c++) begin
			if (bus.bl[c] != bus.blb[c]) begin
				resolved[c] = bus.bl[c];
			end else begin
				resolved[c] = 1'b0;
			end
		end
	end

	// data_out holds until the next read samples
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_out <= '0;
		end else if (bus.sample) begin
			data_out <= resolved;
		end
	end

	// Valid lands in the DONE cycle for one clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_valid <= 1'b0;
		end else begin
			data_valid <= bus.sample;
		end
	end

endmodule

// ==== verilog/cell_array.sv ====
`timescale 1ns/1ps

module cell_array (
	input  logic            clk,
	input  logic            rst_n,
	input  sram_pkg::word_t write_data,
	input  logic            accept_write,
	sram_bitline_if.array   bus
);
	import sram_pkg::*;

	word_t     cells [ROWS];
	word_t     wdata_q;
	wordline_t wordline;
	word_t     read_word;

	// Write driver latch, captured on the edge that accepts the write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wdata_q <= '0;
		end else if (accept_write) begin
			wdata_q <= write_data;
		end
	end

	// Row decoder
	always_comb begin
		wordline = '0;
		wordline[bus.row_addr] = 1'b1;
	end

	// Storage cells, only the row on the active wordline takes the word
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < ROWS; r++) begin
				cells[r] <= '0;
			end
		end else if (bus.row_en && bus.write_en) begin
			for (int r = 0; r < ROWS; r++) begin
				if (wordline[r]) begin
					cells[r] <= wdata_q;
				end
			end
		end
	end

	// Wired-OR of all rows gated by their wordline
	always_comb begin
		read_word = '0;
		for (int r = 0; r < ROWS; r++) begin
			if (wordline[r]) begin
				read_word = read_word | cells[r];
			end
		end
	end

	// Bitline pair
	// precharge pulls both lines high, a read row splits them,
	// otherwise both lines rest low
	always_comb begin
		if (bus.precharge) begin
			bus.bl  = '1;
			bus.blb = '1;
		end else if (bus.row_en && !bus.write_en) begin
			bus.bl  = read_word;
			bus.blb = ~read_word;
		end else begin
			bus.bl  = '0;
			bus.blb = '0;
		end
	end

endmodule

// ==== verilog/sipo.sv ====
`timescale 1ns/1ps

module sipo (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            serial_in,
	input  logic            shift,
	output sram_pkg::word_t parallel_out
);
	import sram_pkg::*;

	word_t shift_q;

	// New bit enters at bit 0, older bits move toward the MSB
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift_q <= '0;
		end else if (shift) begin
			shift_q <= {shift_q[COLS-2:0], serial_in};
		end
	end

	// After COLS shifts the first bit sits in the MSB
	assign parallel_out = shift_q;

endmodule

// ==== verilog/sense_timer.sv ====
`timescale 1ns/1ps

module sense_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic done
);
	import sram_pkg::*;

	sense_cnt_t count;
	logic       running;

	// Loads on start and counts down to zero, then stops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count   <= '0;
			running <= 1'b0;
		end else if (start) begin
			count   <= sense_cnt_t'(SENSE_CYCLES - 1);
			running <= 1'b1;
		end else if (running) begin
			if (count == '0) begin
				running <= 1'b0;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// High during the last sense cycle only
	assign done = running && (count == '0);

endmodule

// ==== verilog/sram_ctrl.sv ====
`timescale 1ns/1ps

module sram_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                w_en,
	input  logic                r_en,
	input  sram_pkg::row_addr_t addr,
	input  logic                sense_done,
	output logic                sense_start,
	output logic                accept_write,
	sram_bitline_if.ctrl        bus
);
	import sram_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	row_addr_t   addr_q;
	logic        accept_read;

	// Pulses only count in IDLE, write takes priority over read
	assign accept_write = (state == IDLE) && w_en;
	assign accept_read  = (state == IDLE) && r_en && !w_en;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Row address is held for the whole access
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_q <= '0;
		end else if (accept_write || accept_read) begin
			addr_q <= addr;
		end
	end

	always_comb begin
		state_next = state;
		unique case (state)
			IDLE: begin
				if (accept_write) begin
					state_next = WRITE;
				end else if (accept_read) begin
					state_next = PRECHARGE;
				end
			end
			// Single cycle with the write driver on the bitlines
			WRITE: begin
				state_next = IDLE;
			end
			PRECHARGE: begin
				state_next = SENSE;
			end
			// Stay until the timer flags the last sense cycle
			SENSE: begin
				if (sense_done) begin
					state_next = DONE;
				end
			end
			DONE: begin
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	// Timer is loaded on the edge that enters SENSE
	assign sense_start = (state == PRECHARGE);

	// Phase strobes onto the bitline bus
	always_comb begin
		bus.row_addr  = addr_q;
		bus.row_en    = (state == WRITE) || (state == SENSE);
		bus.write_en  = (state == WRITE);
		bus.precharge = (state == PRECHARGE);
		bus.sample    = (state == SENSE) && sense_done;
	end

endmodule

// ==== verilog/sram_bitline_if.sv ====
`timescale 1ns/1ps

interface sram_bitline_if;
	import sram_pkg::*;

	// Row select and phase strobes from the controller
	row_addr_t row_addr;
	logic      row_en;
	logic      write_en;
	logic      precharge;
	logic      sample;

	// Bitline pair driven by the selected cells
	word_t bl;
	word_t blb;

	modport ctrl (
		output row_addr,
		output row_en,
		output write_en,
		output precharge,
		output sample
	);

	modport array (
		input  row_addr,
		input  row_en,
		input  write_en,
		input  precharge,
		output bl,
		output blb
	);

	modport sense (
		input bl,
		input blb,
		input sample
	);

endinterface

// ==== verilog/sram_pkg.sv ====
package sram_pkg;

	// Array geometry
	localparam int ROWS   = 16;
	localparam int COLS   = 8;
	localparam int ADDR_W = 4;

	// Number of clock cycles the bitlines are given to develop
	localparam int SENSE_CYCLES = 3;

	// Counter width for the sense timer, wide enough for SENSE_CYCLES-1
	localparam int SENSE_CNT_W = $clog2(SENSE_CYCLES + 1);

	// One data word as it sits on the bitlines
	typedef logic [COLS-1:0] word_t;

	// Row address as presented on the addr pins
	typedef logic [ADDR_W-1:0] row_addr_t;

	// One-hot wordline select, one bit per row
	typedef logic [ROWS-1:0] wordline_t;

	// Down-count value of the sense timer
	typedef logic [SENSE_CNT_W-1:0] sense_cnt_t;

	// Access sequencing in the controller
	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		PRECHARGE,
		SENSE,
		DONE
	} ctrl_state_t;

endpackage
